//--- hdl/cache_data_array.sv
/*
  Data store, 2 ways by 64 sets by 8 words.
  The read address is registered and the word is picked from the array in
  the next cycle, so a write on the same edge is already visible. One
  write per cycle; the caller merges fill and store writes.
*/
`timescale 1ns/1ns
`default_nettype none

module cache_data_array (
  input  wire logic                 clk,
  input  wire cache_pkg::addr_t     rd_addr,
  input  wire logic                 rd_way,
  input  wire cache_pkg::array_wr_t array_wr,
  input  wire logic                 wr_way,
  output cache_pkg::word_t          rd_data
);

  cache_pkg::word_t     mem [2][cache_pkg::num_sets][cache_pkg::words_per_line];
  cache_pkg::index_t    rd_set;            // Registered set.
  cache_pkg::word_sel_t rd_word;           // Registered word in the line.

  always_ff @(posedge clk) begin
    if (array_wr.data_we)
      mem[wr_way][cache_pkg::index_of(array_wr.addr)][cache_pkg::word_of(array_wr.addr)] <=
        array_wr.data;
    rd_set  <= cache_pkg::index_of(rd_addr);
    rd_word <= cache_pkg::word_of(rd_addr);
  end

  assign rd_data = mem[rd_way][rd_set][rd_word]; // Way chosen late, by the compare.

endmodule

`default_nettype wire

//--- hdl/cache_fill_ctrl.sv
/*
  Line fill controller for a load miss.
  A miss is taken only in idle. The fill waits for grant with no time
  limit, then issues eight reads on consecutive cycles. Returned words must
  arrive exactly mem_latency cycles after their address, as main_memory
  guarantees; the write address comes from a fixed delay line.
*/
`timescale 1ns/1ns
`default_nettype none

module cache_fill_ctrl (
  input  wire logic                 clk,
  input  wire logic                 rst,
  input  wire logic                 miss_detected,
  input  wire cache_pkg::addr_t     miss_addr,
  input  wire logic                 grant,
  input  wire logic                 data_valid,
  input  wire cache_pkg::word_t     mem_rdata,
  input  wire logic                 victim_way,
  output logic                      busy,
  output cache_pkg::mem_req_t       mem_req,
  output cache_pkg::array_wr_t      array_wr,
  output logic                      fill_way
);

  cache_pkg::fill_state_t state;           // Current state.
  cache_pkg::fill_state_t nxt_state;       // Next state.
  cache_pkg::addr_t       rd_addr;         // Next word address sent to memory.
  cache_pkg::addr_t       wr_addr [cache_pkg::mem_latency]; // Addresses still in flight.
  cache_pkg::word_sel_t   word_cnt;        // Words already written into the line.
  cache_pkg::tag_entry_t  new_tag;         // Entry written with the last word.
  logic                   mem_en;          // Read strobe toward memory.
  logic                   start_fill;      // Capture the miss.
  logic                   set_mem_en;      // Grant seen, start reading.
  logic                   last_addr;       // Eighth address on the port now.
  logic                   last_word;       // Eighth word returning now.
  logic                   wr_data;         // Write a returned word.

  //////////////////////////////
  // State and set/clear flops
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (rst)
      state <= cache_pkg::idle;
    else
      state <= nxt_state;
  end

  // Stall for the core. It falls on the edge that writes the tag.
  always_ff @(posedge clk) begin
    if (rst)
      busy <= 1'b0;
    else if (start_fill)
      busy <= 1'b1;
    else if (last_word)
      busy <= 1'b0;
  end

  // Read strobe stays up for exactly one line worth of addresses.
  always_ff @(posedge clk) begin
    if (rst)
      mem_en <= 1'b0;
    else if (set_mem_en)
      mem_en <= 1'b1;
    else if (last_addr)
      mem_en <= 1'b0;
  end

  assign last_addr = mem_en &&
                     cache_pkg::word_of(rd_addr) == cache_pkg::word_sel_t'(cache_pkg::words_per_line - 1);
  assign last_word = wr_data &&
                     word_cnt == cache_pkg::word_sel_t'(cache_pkg::words_per_line - 1);

  //////////////////////////////
  // Counters
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (rst)
      rd_addr <= '0;
    else if (start_fill)
      rd_addr <= {miss_addr[15:4], 4'h0};  // Line base, first word.
    else if (mem_en)
      rd_addr <= rd_addr + 16'd2;          // One word per cycle.
  end

  // Three bits wrap back to zero after the eighth word.
  always_ff @(posedge clk) begin
    if (rst)
      word_cnt <= '0;
    else if (start_fill)
      word_cnt <= '0;
    else if (wr_data)
      word_cnt <= word_cnt + 3'd1;
  end

  // The delay line matches the memory pipeline, so the tail holds the address of the
  // word arriving in the same cycle.
  always_ff @(posedge clk) begin
    wr_addr[0] <= rd_addr;
    for (int i = 1; i < cache_pkg::mem_latency; i++)
      wr_addr[i] <= wr_addr[i-1];
  end

  // Victim and new entry are fixed for the whole fill.
  always_ff @(posedge clk) begin
    if (start_fill) begin
      new_tag  <= '{tag: cache_pkg::tag_of(miss_addr), valid: 1'b1, lru: 1'b0};
      fill_way <= victim_way;
    end
  end

  //////////////////////////////
  // Next state
  //////////////////////////////
  always_comb begin
    nxt_state  = state;                    // Hold by default.
    start_fill = 1'b0;
    set_mem_en = 1'b0;
    wr_data    = 1'b0;
    case (state)
      cache_pkg::idle: begin
        if (miss_detected) begin
          start_fill = 1'b1;               // Latch address, victim and tag.
          nxt_state  = cache_pkg::wait_grant;
        end
      end
      cache_pkg::wait_grant: begin
        if (grant) begin
          set_mem_en = 1'b1;               // First address goes out next cycle.
          nxt_state  = cache_pkg::send;
        end
      end
      cache_pkg::send: begin
        wr_data = data_valid;              // Every returned word lands in the line.
        if (last_word)
          nxt_state = cache_pkg::idle;
      end
      default: nxt_state = cache_pkg::idle;
    endcase
  end

  assign mem_req  = '{mem_en: mem_en, write: 1'b0, addr: rd_addr, wdata: '0};
  assign array_wr = '{data_we: wr_data,
                      tag_we:  last_word,
                      addr:    wr_addr[cache_pkg::mem_latency-1],
                      data:    mem_rdata,
                      tag:     new_tag};

endmodule

`default_nettype wire

//--- hdl/cache_pkg.sv
/*
  Shared types and geometry of the two-way instruction-side cache.
  Addresses are 16-bit byte addresses. Data moves as 16-bit words only,
  so address bit 0 is ignored everywhere. Line size, set count and
  memory latency are fixed here, and the RTL supports no other values.
*/
`default_nettype none

package cache_pkg;

  //////////////////////////////
  // Geometry and timing
  //////////////////////////////
  localparam int addr_w         = 16;       // Byte address width.
  localparam int word_w         = 16;       // Data word width.
  localparam int tag_w          = 6;        // Address bits 15 to 10.
  localparam int index_w        = 6;        // Address bits 9 to 4.
  localparam int sel_w          = 3;        // Address bits 3 to 1.
  localparam int num_sets       = 64;       // Sets per way.
  localparam int words_per_line = 8;        // Sixteen bytes per line.
  localparam int mem_latency    = 4;        // Cycles from address to data_valid.
  localparam int mem_words      = 32768;    // Full 64 KB space in words.
  localparam logic [15:0] mem_init = 16'hA5C3; // Word at byte a starts as a ^ mem_init.

  typedef logic [addr_w-1:0]  addr_t;
  typedef logic [word_w-1:0]  word_t;
  typedef logic [tag_w-1:0]   tag_t;
  typedef logic [index_w-1:0] index_t;
  typedef logic [sel_w-1:0]   word_sel_t;

  typedef struct packed {
    tag_t tag;
    logic valid;
    logic lru;                              // Set on the way to replace next.
  } tag_entry_t;

  typedef struct packed {
    logic  mem_en;
    logic  write;
    addr_t addr;
    word_t wdata;
  } mem_req_t;

  typedef struct packed {
    logic       data_we;
    logic       tag_we;
    addr_t      addr;                       // Word address inside the target line.
    word_t      data;
    tag_entry_t tag;
  } array_wr_t;

  typedef enum logic [1:0] {idle, wait_grant, send} fill_state_t;

  // Field extraction from a byte address.
  function automatic tag_t tag_of(addr_t a);
    return a[15:10];
  endfunction

  function automatic index_t index_of(addr_t a);
    return a[9:4];
  endfunction

  function automatic word_sel_t word_of(addr_t a);
    return a[3:1];
  endfunction

endpackage

`default_nettype wire

//--- hdl/cache_tag_array.sv
/*
  Two-way tag store, 64 sets, with one LRU bit per entry.
  The index is registered, so the compare runs in the cycle after the
  index is given. A tag write and an access never fall in the same
  cycle; if they did the tag write would win.
*/
`timescale 1ns/1ns
`default_nettype none

module cache_tag_array (
  input  wire logic                 clk,
  input  wire logic                 rst,
  input  wire cache_pkg::index_t    rd_index,
  input  wire cache_pkg::tag_t      lookup_tag,
  input  wire logic                 access,
  input  wire cache_pkg::array_wr_t array_wr,
  input  wire logic                 fill_way,
  output logic                      hit,
  output logic                      hit_way,
  output logic                      victim_way
);

  cache_pkg::tag_entry_t entry [2][cache_pkg::num_sets]; // Way, then set.
  cache_pkg::index_t     idx_q;            // Set under lookup.
  cache_pkg::index_t     wr_index;         // Set being filled.
  cache_pkg::tag_entry_t way0;
  cache_pkg::tag_entry_t way1;
  logic                  hit0;
  logic                  hit1;

  always_ff @(posedge clk) begin
    idx_q <= rd_index;
  end

  assign wr_index = cache_pkg::index_of(array_wr.addr);
  assign way0     = entry[0][idx_q];
  assign way1     = entry[1][idx_q];

  //////////////////////////////
  // Compare
  //////////////////////////////
  assign hit0    = way0.valid && way0.tag == lookup_tag;
  assign hit1    = way1.valid && way1.tag == lookup_tag;
  assign hit     = hit0 || hit1;
  assign hit_way = hit1;                   // Both ways never hold the same tag.

  // The two LRU bits of a set are never both set, so way 1 is the victim only
  // when its own bit says so.
  assign victim_way = way1.lru;

  //////////////////////////////
  // Update
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int s = 0; s < cache_pkg::num_sets; s++) begin
        entry[0][s] <= '0;                 // Invalid, no victim preference.
        entry[1][s] <= '0;
      end
    end else if (array_wr.tag_we) begin
      entry[fill_way][wr_index]      <= array_wr.tag; // Arrives valid and most recent.
      entry[!fill_way][wr_index].lru <= 1'b1;
    end else if (access && hit) begin
      entry[hit_way][idx_q].lru  <= 1'b0;
      entry[!hit_way][idx_q].lru <= 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- hdl/cache_top.sv
/*
  The cache top holds the lookup stage, the store path and the four blocks.
  A request is taken when req is high and stall is low. Stall rises only in
  the cycle after a load miss, so a request given in the lookup cycle of a
  missing load is lost; drivers leave one idle cycle after each load.
  Loads and stores that hit both refresh the LRU bits.
*/
`timescale 1ns/1ns
`default_nettype none

module cache_top (
  input  wire logic             clk,
  input  wire logic             rst,
  input  wire logic             req,
  input  wire logic             req_write,
  input  wire cache_pkg::addr_t req_addr,
  input  wire cache_pkg::word_t req_wdata,
  input  wire logic             grant,
  output logic                  stall,
  output logic                  rd_valid,
  output cache_pkg::word_t      rd_data
);

  logic                 lk_valid;          // Lookup this cycle.
  logic                 lk_write;
  cache_pkg::addr_t     lk_addr;
  cache_pkg::word_t     lk_wdata;
  cache_pkg::addr_t     look_addr;         // Address the arrays register.
  logic                 replay;            // A missed load waits for its line.
  logic                 take;              // Load the lookup stage.
  logic                 miss;
  logic                 store_hit;
  logic                 hit;
  logic                 hit_way;
  logic                 victim_way;
  logic                 fill_way;
  logic                 wr_way;
  logic                 data_valid;
  cache_pkg::word_t     mem_rdata;
  cache_pkg::mem_req_t  fill_req;
  cache_pkg::mem_req_t  mem_req;
  cache_pkg::array_wr_t fill_wr;
  cache_pkg::array_wr_t data_wr;

  assign take      = req && !stall && !miss;
  assign look_addr = take ? req_addr : lk_addr;  // Held during a fill.

  //////////////////////////////
  // Lookup stage
  //////////////////////////////
  // The held load looks up again on the edge that writes its tag.
  always_ff @(posedge clk) begin
    if (rst) begin
      lk_valid <= 1'b0;
      replay   <= 1'b0;
    end else begin
      lk_valid <= take || (replay && fill_wr.tag_we);
      replay   <= miss || (replay && !fill_wr.tag_we);
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      lk_write <= req_write;
      lk_addr  <= req_addr;
      lk_wdata <= req_wdata;
    end
  end

  assign miss      = lk_valid && !lk_write && !hit;
  assign store_hit = lk_valid && lk_write && hit;
  assign rd_valid  = lk_valid && !lk_write && hit;

  // Stores go straight to memory. A hit also patches the line in the cache.
  always_comb begin
    mem_req = fill_req;
    data_wr = fill_wr;
    wr_way  = fill_way;
    if (lk_valid && lk_write) begin
      mem_req.mem_en = 1'b1;
      mem_req.write  = 1'b1;
      mem_req.addr   = lk_addr;
      mem_req.wdata  = lk_wdata;
    end
    if (store_hit) begin
      data_wr.data_we = 1'b1;
      data_wr.addr    = lk_addr;
      data_wr.data    = lk_wdata;
      wr_way          = hit_way;
    end
  end

  cache_fill_ctrl i_fill_ctrl (
    .clk(clk), .rst(rst), .miss_detected(miss), .miss_addr(lk_addr), .grant(grant),
    .data_valid(data_valid), .mem_rdata(mem_rdata), .victim_way(victim_way),
    .busy(stall), .mem_req(fill_req), .array_wr(fill_wr), .fill_way(fill_way)
  );

  cache_tag_array i_tag_array (
    .clk(clk), .rst(rst), .rd_index(cache_pkg::index_of(look_addr)),
    .lookup_tag(cache_pkg::tag_of(lk_addr)), .access(lk_valid), .array_wr(fill_wr),
    .fill_way(fill_way), .hit(hit), .hit_way(hit_way), .victim_way(victim_way)
  );

  cache_data_array i_data_array (
    .clk(clk), .rd_addr(look_addr), .rd_way(hit_way), .array_wr(data_wr),
    .wr_way(wr_way), .rd_data(rd_data)
  );

  main_memory i_main_memory (
    .clk(clk), .rst(rst), .mem_req(mem_req), .data_valid(data_valid), .rdata(mem_rdata)
  );

endmodule

`default_nettype wire

//--- hdl/main_memory.sv
/*
  Main memory simulation model, 32K words, not meant for synthesis.
  Every word starts as its byte address XOR mem_init. A write lands on the
  edge it is presented. Reads return mem_latency cycles later, one per
  cycle, and any number may be in flight. The word is read when it leaves
  the pipeline.
*/
`timescale 1ns/1ns
`default_nettype none

module main_memory (
  input  wire logic                clk,
  input  wire logic                rst,
  input  wire cache_pkg::mem_req_t mem_req,
  output logic                     data_valid,
  output cache_pkg::word_t         rdata
);

  cache_pkg::word_t mem [cache_pkg::mem_words];
  logic [cache_pkg::mem_latency-1:0] rd_vld;                  // Stage valid bits.
  cache_pkg::addr_t rd_adr [cache_pkg::mem_latency];          // Stage addresses.

  initial begin
    for (int i = 0; i < cache_pkg::mem_words; i++)
      mem[i] = cache_pkg::word_t'(2 * i) ^ cache_pkg::mem_init;
  end

  // Word index is the byte address without bit 0.
  always @(posedge clk) begin
    if (mem_req.mem_en && mem_req.write)
      mem[mem_req.addr[15:1]] <= mem_req.wdata;
  end

  //////////////////////////////
  // Read pipeline
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (rst)
      rd_vld <= '0;
    else
      rd_vld <= {rd_vld[cache_pkg::mem_latency-2:0], mem_req.mem_en && !mem_req.write};
  end

  always_ff @(posedge clk) begin
    rd_adr[0] <= mem_req.addr;
    for (int i = 1; i < cache_pkg::mem_latency; i++)
      rd_adr[i] <= rd_adr[i-1];
  end

  assign data_valid = rd_vld[cache_pkg::mem_latency-1];
  assign rdata      = mem[rd_adr[cache_pkg::mem_latency-1][15:1]];

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build the cache testbench with Verilator, run it, and look for the pass line.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module cache_tb -o cache_sim
out=$(./obj_dir/cache_sim +verilator+error+limit+1000 2>&1) || true
echo "$out"
echo "$out" | grep -q '^\*\*\* PASSED \*\*\*$'

//--- tests/cache_input.txt
# op (L load, S store), byte address hex, store data hex, grant delay in cycles
# a grant delay of -1 takes the delay from the LFSR
L 0100 0000 2
L 0100 0000 0
L 0102 0000 0
L 0104 0000 0
L 0106 0000 0
L 0108 0000 0
L 010A 0000 0
L 010C 0000 0
L 010E 0000 0
L 0500 0000 5
L 0104 0000 0
L 0902 0000 1
L 0106 0000 0
L 0500 0000 3
L 0108 0000 0
S 0108 BEEF 0
L 0108 0000 0
S 2A30 1234 0
L 2A30 0000 4
L 2A32 0000 0
S 0506 7777 0
L 0506 0000 0
L 3F00 0000 60
L 3F0E 0000 0
L 4C20 0000 -1
L 7E44 0000 -1
L FFFE 0000 -1
S 8000 55AA 0
L 8000 0000 -1
L 8002 0000 0
L 0902 0000 -1
L 0100 0000 -1
L 0500 0000 0

//--- tests/cache_properties.sv
/*
  Assertions on the line fill controller, bound into every cache_fill_ctrl.
  They assume the fixed eight-word line and are off while rst is high.
*/
`timescale 1ns/1ns
`default_nettype none

module cache_properties (
  input wire logic                   clk,
  input wire logic                   rst,
  input wire cache_pkg::fill_state_t state,
  input wire logic                   busy,
  input wire logic                   mem_en,
  input wire logic                   data_we,
  input wire logic                   tag_we,
  input wire logic                   data_valid
);

  int         fail_cnt = 0;                      // Assertion firings so far.
  logic [3:0] en_run;                            // Cycles of mem_en seen in this burst.
  logic [3:0] wr_cnt;                            // Line words written in this fill.

  always_ff @(posedge clk) begin
    if (rst)
      en_run <= '0;
    else if (mem_en)
      en_run <= en_run + 4'd1;
    else
      en_run <= '0;
  end

  // Counts the words written while stall is up, cleared between fills.
  always_ff @(posedge clk) begin
    if (rst || !busy)
      wr_cnt <= '0;
    else if (data_we)
      wr_cnt <= wr_cnt + 4'd1;
  end

  //////////////////////////////
  // Stall
  //////////////////////////////
  stall_fall: assert property (@(posedge clk) disable iff (rst)
    $fell(busy) |-> $past(tag_we) && $past(wr_cnt) == 4'd7)
    else begin fail_cnt++; $error("stall fell without eight words and a tag write"); end

  //////////////////////////////
  // Memory burst and writes
  //////////////////////////////
  burst_max: assert property (@(posedge clk) disable iff (rst)
    mem_en |-> en_run < 4'd8 && state == cache_pkg::send)
    else begin fail_cnt++; $error("mem_en high for more than eight cycles or outside send"); end

  burst_len: assert property (@(posedge clk) disable iff (rst) $fell(mem_en) |-> en_run == 4'd8)
    else begin fail_cnt++; $error("mem_en burst was not eight cycles long"); end

  write_on_data: assert property (@(posedge clk) disable iff (rst) data_we == data_valid)
    else begin fail_cnt++; $error("data array write and data_valid disagree"); end

endmodule

bind cache_fill_ctrl cache_properties i_props (
  .clk(clk), .rst(rst), .state(state), .busy(busy), .mem_en(mem_req.mem_en),
  .data_we(array_wr.data_we), .tag_we(array_wr.tag_we), .data_valid(data_valid)
);

`default_nettype wire

//--- tests/cache_tb.sv
/*
  Testbench for cache_top. Operations come from tests/cache_input.txt and
  run one at a time, each followed by one idle cycle, since the cache drops
  a request made in the lookup cycle of a missing load. Expected data and
  hit or miss come from a memory model and a tag and LRU model kept here.
  A grant delay of -1 in the file is drawn from a 32-bit LFSR.
*/
`timescale 1ns/1ns
`default_nettype none

module cache_tb;

  localparam int max_ops = 256;                  // Room for the operation list.

  logic             clk;
  logic             rst;
  logic             req;
  logic             req_write;
  cache_pkg::addr_t req_addr;
  cache_pkg::word_t req_wdata;
  logic             grant;
  logic             stall;
  logic             rd_valid;
  cache_pkg::word_t rd_data;

  logic [7:0]       op_kind [max_ops];           // L for load, S for store.
  cache_pkg::addr_t op_addr [max_ops];
  cache_pkg::word_t op_data [max_ops];
  int               op_delay [max_ops];          // Grant delay, -1 for random.
  int               num_ops = 0;
  logic             ops_loaded = 1'b0;           // Starts the watchdog.
  int               errors = 0;
  logic [31:0]      lfsr = 32'h3b75_449b;

  cache_pkg::word_t ref_mem [32768];             // Memory as the core should see it.
  logic             m_valid [2][64];             // Way, then set.
  cache_pkg::tag_t  m_tag [2][64];
  logic             m_lru [2][64];               // Set on the way to replace next.

  cache_top i_dut (
    .clk(clk), .rst(rst), .req(req), .req_write(req_write), .req_addr(req_addr),
    .req_wdata(req_wdata), .grant(grant), .stall(stall), .rd_valid(rd_valid),
    .rd_data(rd_data)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;                      // 100 ns period.
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////
  // Taps 32, 22, 2 and 1.
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_delay(output int dly);
    dly = 0;
    for (int i = 0; i < 5; i++) begin            // Five bits, 0 to 31 cycles.
      lfsr = lfsr_next(lfsr);
      dly  = (dly << 1) | int'(lfsr[0]);
    end
  endtask

  task automatic expect_equal(string name, logic [31:0] actual, logic [31:0] expected);
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
    end
  endtask

  task automatic load_ops();
    int          fd;
    int          n;
    string       line;
    logic [7:0]  kind;
    logic [15:0] a;
    logic [15:0] d;
    int          dly;
    fd = $fopen("tests/cache_input.txt", "r");
    if (fd == 0) begin
      $display("Cannot open tests/cache_input.txt for reading");
      return;
    end
    while (!$feof(fd) && num_ops < max_ops) begin
      n = $fgets(line, fd);
      if (n > 0 && line.getc(0) != "#") begin    // Hash lines describe the columns.
        n = $sscanf(line, "%c %h %h %d", kind, a, d, dly);
        if (n == 4) begin
          op_kind[num_ops]  = kind;
          op_addr[num_ops]  = a;
          op_data[num_ops]  = d;
          op_delay[num_ops] = dly;
          num_ops++;
        end
      end
    end
    $fclose(fd);
  endtask

  //////////////////////////////
  // Cache state model
  //////////////////////////////
  task automatic model_lookup(input cache_pkg::addr_t a, output logic hit, output logic way);
    logic [5:0] set;
    set = a[9:4];
    hit = 1'b0;
    way = 1'b0;
    for (int w = 0; w < 2; w++) begin
      if (m_valid[w][set] && m_tag[w][set] == a[15:10]) begin
        hit = 1'b1;
        way = w[0];
      end
    end
  endtask

  // The touched way becomes most recent.
  task automatic model_touch(cache_pkg::addr_t a, logic way);
    m_lru[way][a[9:4]]  = 1'b0;
    m_lru[!way][a[9:4]] = 1'b1;
  endtask

  task automatic model_fill(cache_pkg::addr_t a);
    logic victim;
    victim = !m_lru[0][a[9:4]] && m_lru[1][a[9:4]]; // Way 0 unless only way 1 is marked.
    m_valid[victim][a[9:4]] = 1'b1;
    m_tag[victim][a[9:4]]   = a[15:10];
    model_touch(a, victim);
  endtask

  //////////////////////////////
  // Operations
  //////////////////////////////
  // Called on a falling edge. Returns on the falling edge of the lookup cycle.
  task automatic issue(logic write, cache_pkg::addr_t a, cache_pkg::word_t d);
    req       = 1'b1;
    req_write = write;
    req_addr  = a;
    req_wdata = d;
    @(negedge clk);
    req       = 1'b0;
  endtask

  task automatic run_load(cache_pkg::addr_t a, int file_delay);
    logic             hit;
    logic             way;
    int               dly;
    cache_pkg::word_t expected;
    expected = ref_mem[a[15:1]];
    model_lookup(a, hit, way);
    issue(1'b0, a, '0);
    if (hit) begin
      expect_equal("stall", 32'(stall), 32'd0);
      expect_equal("rd_valid", 32'(rd_valid), 32'd1);
      expect_equal("rd_data", 32'(rd_data), 32'(expected));
      model_touch(a, way);
    end else begin
      expect_equal("rd_valid", 32'(rd_valid), 32'd0);
      @(negedge clk);
      expect_equal("stall", 32'(stall), 32'd1);    // Raised one cycle after the miss.
      dly = file_delay;
      if (dly < 0)
        draw_delay(dly);
      repeat (dly) begin                          // Grant held back.
        @(negedge clk);
        expect_equal("stall", 32'(stall), 32'd1);
        expect_equal("rd_valid", 32'(rd_valid), 32'd0);
      end
      grant = 1'b1;
      while (stall) begin
        expect_equal("rd_valid", 32'(rd_valid), 32'd0);
        @(negedge clk);
      end
      grant = 1'b0;
      expect_equal("rd_valid", 32'(rd_valid), 32'd1); // Replayed load hits.
      expect_equal("rd_data", 32'(rd_data), 32'(expected));
      model_fill(a);
    end
    @(negedge clk);
    expect_equal("rd_valid", 32'(rd_valid), 32'd0);  // One pulse per load.
    expect_equal("stall", 32'(stall), 32'd0);
  endtask

  task automatic run_store(cache_pkg::addr_t a, cache_pkg::word_t d);
    logic hit;
    logic way;
    model_lookup(a, hit, way);
    issue(1'b1, a, d);
    expect_equal("stall", 32'(stall), 32'd0);
    expect_equal("rd_valid", 32'(rd_valid), 32'd0);
    ref_mem[a[15:1]] = d;                          // Write-through, always.
    if (hit)
      model_touch(a, way);                         // No allocation on a miss.
    @(negedge clk);
    expect_equal("stall", 32'(stall), 32'd0);
    expect_equal("rd_valid", 32'(rd_valid), 32'd0);
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////
  initial begin
    rst       = 1'b1;
    req       = 1'b0;
    req_write = 1'b0;
    req_addr  = '0;
    req_wdata = '0;
    grant     = 1'b0;
    for (int i = 0; i < 32768; i++)
      ref_mem[i] = 16'(2 * i) ^ 16'hA5C3;          // Word at byte a holds a ^ A5C3.
    for (int w = 0; w < 2; w++) begin
      for (int s = 0; s < 64; s++) begin
        m_valid[w][s] = 1'b0;
        m_tag[w][s]   = '0;
        m_lru[w][s]   = 1'b0;
      end
    end
    load_ops();
    ops_loaded = 1'b1;
    repeat (10) @(negedge clk);
    rst = 1'b0;
    repeat (3) begin                               // Quiet before the first request.
      @(negedge clk);
      expect_equal("stall", 32'(stall), 32'd0);
      expect_equal("rd_valid", 32'(rd_valid), 32'd0);
    end
    if (num_ops == 0) begin
      errors++;
      $display("No operations were read from tests/cache_input.txt");
    end
    for (int k = 0; k < num_ops; k++) begin
      if (op_kind[k] == "S" || op_kind[k] == "s")
        run_store(op_addr[k], op_data[k]);
      else
        run_load(op_addr[k], op_delay[k]);
    end
    errors += i_dut.i_fill_ctrl.i_props.fail_cnt;
    $display("Ran %0d operations, %0d errors", num_ops, errors);
    if (errors == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

  // Two hundred cycles per operation is far above the longest grant delay plus a fill.
  initial begin
    wait (ops_loaded);
    repeat (num_ops * 200 + 20) @(posedge clk);
    $display("Timeout: the operations did not finish within the cycle budget");
    $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
hdl/cache_pkg.sv
hdl/cache_fill_ctrl.sv
hdl/cache_tag_array.sv
hdl/cache_data_array.sv
hdl/main_memory.sv
hdl/cache_top.sv
tests/cache_properties.sv
tests/cache_tb.sv
